// File: source/memtest_pkg.sv
// Shared types and constants for the memory tester monitor

package memtest_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Constants
    ////////////////////////////////////////////////////////////////////////////

    localparam int PHASE_W      = 7;   // Phase position width, wraps at 128
    localparam int SECS_PER_MIN = 60;

    ////////////////////////////////////////////////////////////////////////////
    // Button and phase command
    ////////////////////////////////////////////////////////////////////////////

    // Board buttons used by the monitor
    typedef struct packed {
        logic phase_up;    // Step PLL phase forward
        logic phase_down;  // Step PLL phase back
    } btn_t;

    // Command towards the dynamic PLL phase port
    typedef struct packed {
        logic step;        // One-cycle strobe
        logic dir;         // 1 up, 0 down
    } phase_cmd_t;

    ////////////////////////////////////////////////////////////////////////////
    // Display words
    ////////////////////////////////////////////////////////////////////////////

    // Phase position in decimal, 000 to 127
    typedef struct packed {
        logic [3:0] hundreds;
        logic [3:0] tens;
        logic [3:0] units;
    } bcd3_t;

    // Minutes in decimal, 0000 to 9999
    typedef struct packed {
        logic [3:0] thousands;
        logic [3:0] hundreds;
        logic [3:0] tens;
        logic [3:0] units;
    } bcd4_t;

    // Everything the display needs in one word
    typedef struct packed {
        bcd3_t       phase_bcd;  // Current phase position
        logic [15:0] secs;       // Elapsed seconds, binary
        bcd4_t       mins;       // Elapsed minutes, BCD
    } monitor_status_t;

endpackage

// File: source/button_debouncer.sv
`timescale 1ns/1ps

// Quiet-window debouncer for the phase buttons
// Samples only once the window counter has its MSB set,
// so any bounce inside one window is never seen twice
module button_debouncer #(
    parameter int DEBOUNCE_BITS = 16
) (
    input  logic               clk_gui,
    input  logic               timer_reset,
    input  memtest_pkg::btn_t  btn,        // Raw, may bounce
    output memtest_pkg::btn_t  btn_deb,    // Debounced sample
    output logic               btn_new     // Strobe on debounced change
);
    import memtest_pkg::*;

    logic [DEBOUNCE_BITS-1:0] window_cnt;  // Quiet-window timer
    btn_t                     btn_cur;     // Latest sample
    btn_t                     btn_prev;    // Sample before that
    logic                     window_open;

    assign window_open = window_cnt[DEBOUNCE_BITS-1];  // MSB marks end of window

    ////////////////////////////////////////////////////////////////////////////
    // Window counter and sampling
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            window_cnt <= '0;
            btn_cur    <= '0;
            btn_prev   <= '0;
            btn_new    <= 1'b0;
        end else begin
            btn_new <= 1'b0;  // Strobe by default low
            if (window_open) begin
                // Window open, sample every cycle
                btn_cur  <= btn;
                btn_prev <= btn_cur;
                if (btn_cur != btn_prev) begin
                    window_cnt <= '0;    // Restart quiet window
                    btn_new    <= 1'b1;  // Announce the change
                end
            end else begin
                window_cnt <= window_cnt + 1'b1;  // Still waiting
            end
        end
    end

    // Sample register holds while the window is closed
    assign btn_deb = btn_cur;

endmodule

// File: source/phase_stepper.sv
`timescale 1ns/1ps

// Turns debounced up/down presses into single PLL phase steps
// and keeps track of where the phase currently sits
module phase_stepper (
    input  logic                             clk_gui,
    input  logic                             timer_reset,
    input  memtest_pkg::btn_t                btn_deb,
    input  logic                             btn_new,
    output memtest_pkg::phase_cmd_t          phase_cmd,
    output logic [memtest_pkg::PHASE_W-1:0]  phase
);
    import memtest_pkg::*;

    logic       step_lvl;      // Either button held
    logic       dir_lvl;       // Up button held
    logic       step_lvl_old;  // Level one cycle back
    logic       step_rise;
    phase_cmd_t cmd_q;

    ////////////////////////////////////////////////////////////////////////////
    // Latch the button levels on each debounced change
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            step_lvl <= 1'b0;
            dir_lvl  <= 1'b0;
        end else if (btn_new) begin
            step_lvl <= btn_deb.phase_up | btn_deb.phase_down;
            dir_lvl  <= btn_deb.phase_up;  // Up wins if both held
        end
    end

    // Only the press matters, release drops the level quietly
    assign step_rise = step_lvl & ~step_lvl_old;

    ////////////////////////////////////////////////////////////////////////////
    // Phase position and step strobe
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            step_lvl_old <= 1'b0;
            cmd_q        <= '0;
            phase        <= '0;
        end else begin
            step_lvl_old <= step_lvl;
            cmd_q.step   <= step_rise;  // One cycle per press
            cmd_q.dir    <= dir_lvl;
            if (step_rise) begin
                // Wraps naturally at the width
                if (dir_lvl)
                    phase <= phase + 1'b1;
                else
                    phase <= phase - 1'b1;
            end
        end
    end

    assign phase_cmd = cmd_q;  // Strobe lines up with the phase update

endmodule

// File: source/phase_bcd.sv
`timescale 1ns/1ps

// Binary phase position to three BCD digits
// Shift-and-add-three with one register stage at the output
module phase_bcd (
    input  logic                             clk_gui,
    input  logic                             timer_reset,
    input  logic [memtest_pkg::PHASE_W-1:0]  phase,
    output memtest_pkg::bcd3_t               phase_digits
);
    import memtest_pkg::*;

    logic [11:0] bcd_comb;  // Digits before the register

    ////////////////////////////////////////////////////////////////////////////
    // Double dabble network
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        bcd_comb = '0;
        for (int i = PHASE_W - 1; i >= 0; i--) begin
            // Correct each digit before it doubles
            if (bcd_comb[3:0] >= 4'd5)
                bcd_comb[3:0] = bcd_comb[3:0] + 4'd3;
            if (bcd_comb[7:4] >= 4'd5)
                bcd_comb[7:4] = bcd_comb[7:4] + 4'd3;
            // Hundreds only ever gets the last shifted carry
            bcd_comb = {bcd_comb[10:0], phase[i]};  // Shift next bit in
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_gui) begin
        if (timer_reset)
            phase_digits <= '0;
        else
            phase_digits <= bcd3_t'(bcd_comb);  // Hundreds in the top nibble
    end

endmodule

// File: source/elapsed_timer.sv
`timescale 1ns/1ps

// Elapsed time since the last timer reset
// Seconds in plain binary, minutes as four BCD digits
module elapsed_timer #(
    parameter int TICKS_PER_SEC = 50000000
) (
    input  logic               clk_gui,
    input  logic               timer_reset,
    output logic [15:0]        secs,
    output memtest_pkg::bcd4_t mins
);
    import memtest_pkg::*;

    // One minute of clk_gui overflows 32 bits at board rates
    localparam longint MIN_TICKS = longint'(TICKS_PER_SEC) * SECS_PER_MIN;
    localparam int     SEC_W     = $clog2(TICKS_PER_SEC + 1);
    localparam int     MIN_W     = $clog2(MIN_TICKS + 1);

    localparam logic [SEC_W-1:0] SEC_LAST = SEC_W'(TICKS_PER_SEC - 1);
    localparam logic [MIN_W-1:0] MIN_LAST = MIN_W'(MIN_TICKS - 1);

    logic [SEC_W-1:0] sec_tick;  // Cycles into current second
    logic [MIN_W-1:0] min_tick;  // Cycles into current minute

    ////////////////////////////////////////////////////////////////////////////
    // Seconds
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            sec_tick <= '0;
            secs     <= '0;
        end else if (sec_tick == SEC_LAST) begin
            sec_tick <= '0;
            secs     <= secs + 1'b1;  // Free-running, wraps at 65535
        end else begin
            sec_tick <= sec_tick + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Minutes with decade carry
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            min_tick <= '0;
            mins     <= '0;
        end else if (min_tick == MIN_LAST) begin
            min_tick <= '0;
            if (mins.units != 4'd9) begin
                mins.units <= mins.units + 4'd1;
            end else begin
                mins.units <= 4'd0;  // Carry into tens
                if (mins.tens != 4'd9) begin
                    mins.tens <= mins.tens + 4'd1;
                end else begin
                    mins.tens <= 4'd0;
                    if (mins.hundreds != 4'd9) begin
                        mins.hundreds <= mins.hundreds + 4'd1;
                    end else begin
                        mins.hundreds <= 4'd0;
                        // Top digit, 9999 rolls over to 0000
                        if (mins.thousands != 4'd9)
                            mins.thousands <= mins.thousands + 4'd1;
                        else
                            mins.thousands <= 4'd0;
                    end
                end
            end
        end else begin
            min_tick <= min_tick + 1'b1;
        end
    end

endmodule

// File: source/memtest_monitor.sv
`timescale 1ns/1ps

// Operator monitor of the SDRAM tester
// Debounce, phase step and BCD stages in a row, elapsed timer beside them
module memtest_monitor #(
    parameter int DEBOUNCE_BITS = 16,
    parameter int TICKS_PER_SEC = 50000000
) (
    input  logic                         clk_gui,
    input  logic                         timer_reset,
    input  memtest_pkg::btn_t            btn,        // Raw board buttons
    output memtest_pkg::phase_cmd_t      phase_cmd,  // To PLL phase port
    output memtest_pkg::monitor_status_t status      // To display
);
    import memtest_pkg::*;

    btn_t               btn_deb;
    logic               btn_new;
    logic [PHASE_W-1:0] phase;
    bcd3_t              phase_digits;
    logic [15:0]        secs;
    bcd4_t              mins;

    ////////////////////////////////////////////////////////////////////////////
    // Phase pipeline
    ////////////////////////////////////////////////////////////////////////////

    button_debouncer #(
        .DEBOUNCE_BITS (DEBOUNCE_BITS)
    ) u_debouncer (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .btn         (btn),
        .btn_deb     (btn_deb),
        .btn_new     (btn_new)
    );

    phase_stepper u_stepper (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .btn_deb     (btn_deb),
        .btn_new     (btn_new),
        .phase_cmd   (phase_cmd),
        .phase       (phase)
    );

    phase_bcd u_bcd (
        .clk_gui      (clk_gui),
        .timer_reset  (timer_reset),
        .phase        (phase),
        .phase_digits (phase_digits)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Timer and display word
    ////////////////////////////////////////////////////////////////////////////

    elapsed_timer #(
        .TICKS_PER_SEC (TICKS_PER_SEC)
    ) u_timer (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .secs        (secs),
        .mins        (mins)
    );

    assign status = '{phase_bcd: phase_digits, secs: secs, mins: mins};

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

// Free-running clk_gui and power-on reset for the testbench
module tb_clock #(
    parameter int HALF_PERIOD  = 5,  // 10 ns period
    parameter int RESET_CYCLES = 2
) (
    output logic clk_gui,
    output logic timer_reset
);
    initial begin
        clk_gui = 1'b0;
        forever #HALF_PERIOD clk_gui = ~clk_gui;
    end

    // Held over the first rising edges, dropped on an edge
    initial begin
        timer_reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_gui);
        timer_reset <= 1'b0;
    end

endmodule

// File: test/memtest_monitor_tb.sv
`timescale 1ns/1ps

// Testbench of the memtest monitor
// Random presses with bounce, phase and timer model kept alongside
module memtest_monitor_tb;
    import memtest_pkg::*;

    localparam int DEBOUNCE_BITS  = 4;
    localparam int TICKS_PER_SEC  = 8;
    localparam int WINDOW         = 1 << (DEBOUNCE_BITS - 1);  // Quiet window in cycles
    localparam int STEP_TIMEOUT   = 20 * WINDOW;
    localparam int RELEASE_GAP    = 5 * WINDOW;                // Settle time after release
    localparam int RANDOM_PRESSES = 40;

    logic            clk_gui;
    logic            timer_reset;
    btn_t            btn;
    phase_cmd_t      phase_cmd;
    monitor_status_t status;

    int    seed;
    int    cycle_count;   // Clock edges since reset release
    int    model_phase;   // Expected phase position
    int    check_count;
    int    error_count;
    int    test_checks;   // Counts at test start
    int    test_errors;
    string test_name;
    bit    timed_out;

    tb_clock u_clock (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset)
    );

    memtest_monitor #(
        .DEBOUNCE_BITS (DEBOUNCE_BITS),
        .TICKS_PER_SEC (TICKS_PER_SEC)
    ) UUT (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .btn         (btn),
        .phase_cmd   (phase_cmd),
        .status      (status)
    );

    always @(posedge clk_gui) begin
        if (timer_reset)
            cycle_count <= 0;
        else
            cycle_count <= cycle_count + 1;  // Matches the timer's own tick count
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    // Decimal digits, units in the low nibble
    function automatic logic [15:0] to_decimal(input int value);
        logic [15:0] digits;
        int          rest;
        int          i;
        rest = value;
        for (i = 0; i < 4; i++) begin
            digits[4*i +: 4] = 4'(rest % 10);
            rest = rest / 10;
        end
        return digits;
    endfunction

    // Chatter bits drop the line back to released in cycles 1 and 2
    function automatic btn_t bounce_value(input btn_t press_val, input int cyc,
                                          input logic [1:0] chatter);
        if ((cyc == 1 && chatter[0]) || (cyc == 2 && chatter[1]))
            return '0;
        return press_val;
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count = check_count + 1;
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("Error: %s expected 0x%0h, got 0x%0h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_checks = check_count;
        test_errors = error_count;
    endtask

    task automatic finish_test();
        $display("Test %-15s %5d checks, %0d errors", test_name,
                 check_count - test_checks, error_count - test_errors);
    endtask

    // One cycle with buttons released, no step allowed
    task automatic idle_cycle();
        @(posedge clk_gui);
        btn <= '0;
        @(negedge clk_gui);
        if (phase_cmd.step)
            check_value("phase_cmd.step", 1, 0);
    endtask

    task automatic wait_for_reset_release();
        int guard;
        guard = 0;
        while (timer_reset !== 1'b0 && guard < 16) begin
            @(negedge clk_gui);
            guard = guard + 1;
        end
        if (timer_reset !== 1'b0) begin
            $display("Timeout: timer_reset was never released");
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_for_cycle(input int target);
        int guard;
        int limit;
        guard = 0;
        limit = target - cycle_count + 16;
        while (cycle_count < target && guard < limit) begin
            idle_cycle();
            guard = guard + 1;
        end
        if (cycle_count != target) begin
            $display("Timeout: cycle %0d not reached cleanly, counter at %0d",
                     target, cycle_count);
            timed_out = 1'b1;
        end
    endtask

    // Timer read mid-second, never on an increment edge
    task automatic check_timer_at(input int target);
        wait_for_cycle(target);
        if (!timed_out) begin
            check_value("status.secs", status.secs, (target / TICKS_PER_SEC) & 16'hffff);
            check_value("status.mins", status.mins,
                        to_decimal((target / (TICKS_PER_SEC * SECS_PER_MIN)) % 10000));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // One button press with bounce, hold and release
    ////////////////////////////////////////////////////////////////////////////

    task automatic press_once(input bit up);
        btn_t        press_val;
        logic [1:0]  chatter;        // Bounce in the first quarter window
        logic [15:0] expect_digits;
        int          hold_len;
        int          cyc;
        int          steps;
        logic        step_dir;
        press_val = '0;
        if (up)
            press_val.phase_up = 1'b1;
        else
            press_val.phase_down = 1'b1;
        hold_len    = 5 * WINDOW + int'($unsigned($random(seed)) % 16);  // Past 3 windows
        chatter     = 2'($random(seed));
        model_phase = up ? (model_phase + 1) % 128 : (model_phase + 127) % 128;
        steps       = 0;
        step_dir    = 1'b0;
        cyc         = 0;
        while (steps == 0 && cyc < STEP_TIMEOUT) begin
            @(posedge clk_gui);
            btn <= bounce_value(press_val, cyc, chatter);
            @(negedge clk_gui);
            if (phase_cmd.step) begin
                steps    = steps + 1;
                step_dir = phase_cmd.dir;
            end
            cyc = cyc + 1;
        end
        if (steps == 0) begin
            $display("Timeout: no phase step within %0d cycles of a %s press",
                     STEP_TIMEOUT, up ? "phase_up" : "phase_down");
            timed_out = 1'b1;
            @(posedge clk_gui);
            btn <= '0;
        end else begin
            // Rest of the hold, then release and let it settle
            while (cyc < hold_len + RELEASE_GAP) begin
                @(posedge clk_gui);
                if (cyc < hold_len)
                    btn <= bounce_value(press_val, cyc, chatter);
                else
                    btn <= '0;
                @(negedge clk_gui);
                if (phase_cmd.step)
                    steps = steps + 1;  // Any extra one is a fault
                cyc = cyc + 1;
            end
            expect_digits = to_decimal(model_phase);
            check_value("phase_cmd.step", steps, 1);
            check_value("phase_cmd.dir", step_dir, up);
            check_value("status.phase_bcd", status.phase_bcd, expect_digits[11:0]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_reset_test();
        int i;
        begin_test("reset");
        check_value("phase_cmd.step", phase_cmd.step, 0);
        for (i = 0; i < 6; i++) begin
            idle_cycle();
            check_value("status", status, 0);  // Secs still below one
        end
        for (i = 0; i < 3 * WINDOW; i++)
            idle_cycle();
        finish_test();
    endtask

    task automatic run_timer_test();
        int sec;
        begin_test("timer");
        sec = 0;
        while (sec < 590 && !timed_out) begin
            sec = sec + 1 + int'($unsigned($random(seed)) % 60);
            if (sec < 590 && sec * TICKS_PER_SEC > cycle_count + 6)
                check_timer_at(sec * TICKS_PER_SEC + 2 + int'($unsigned($random(seed)) % 5));
        end
        if (!timed_out)
            check_timer_at(599 * TICKS_PER_SEC + 3);  // Units at 9
        if (!timed_out) begin
            check_timer_at(600 * TICKS_PER_SEC + 4);  // Carry into tens
            check_value("status.mins", status.mins, 16'h0010);
        end
        finish_test();
    endtask

    task automatic run_up_test();
        int i;
        begin_test("phase up");
        for (i = 0; i < 3 && !timed_out; i++)
            press_once(1'b1);
        finish_test();
    endtask

    task automatic run_down_test();
        int  i;
        int  presses;
        bit  seen_wrap;
        begin_test("phase down");
        presses   = model_phase + 2;  // Two past zero
        seen_wrap = 1'b0;
        for (i = 0; i < presses && !timed_out; i++) begin
            press_once(1'b0);
            if (!timed_out && model_phase == 127) begin
                seen_wrap = 1'b1;
                check_value("status.phase_bcd", status.phase_bcd, 12'h127);
            end
        end
        if (!timed_out && !seen_wrap) begin
            $display("Down presses never took the phase below zero");
            error_count = error_count + 1;
        end
        finish_test();
    endtask

    task automatic run_random_test();
        int          i;
        logic [15:0] expect_digits;
        begin_test("random presses");
        for (i = 0; i < RANDOM_PRESSES && !timed_out; i++)
            press_once(1'($random(seed)));
        if (!timed_out) begin
            expect_digits = to_decimal(model_phase % 128);
            check_value("status.phase_bcd", status.phase_bcd, expect_digits[11:0]);
        end
        finish_test();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequence and report
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        btn         <= '0;
        seed        = 10084;
        model_phase = 0;
        check_count = 0;
        error_count = 0;
        timed_out   = 1'b0;
        wait_for_reset_release();
        if (!timed_out)
            run_reset_test();
        if (!timed_out)
            run_timer_test();
        if (!timed_out)
            run_up_test();
        if (!timed_out)
            run_down_test();
        if (!timed_out)
            run_random_test();
        $display("Summary: %0d checks, %0d errors%s", check_count, error_count,
                 timed_out ? ", stopped by a timeout" : "");
        if (error_count == 0 && !timed_out && check_count > 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// File: sim.f
source/memtest_pkg.sv
source/button_debouncer.sv
source/phase_stepper.sv
source/phase_bcd.sv
source/elapsed_timer.sv
source/memtest_monitor.sv
test/tb_clock.sv
test/memtest_monitor_tb.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the monitor testbench
# Exit status 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

TOP=memtest_monitor_tb
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module "$TOP" -f sim.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/V$TOP > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
    exit 0
fi

echo "Pass line not found in $LOG"
exit 1
